//--- Makefile
VERILATOR ?= verilator
TOP       ?= xmodem_rx_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/uart_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_byte_rx #(
    parameter int CYC_PER_BIT = 20
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        rx_pin,
    output logic [7:0] rx_byte,
    output logic       byte_valid
);

    localparam int CNT_W = $clog2(CYC_PER_BIT + 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CYC_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CYC_PER_BIT - 1);
    localparam logic [3:0] LAST_BIT = 4'(xmodem_pkg::UART_FRAME_BITS - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             fall_edge;
    logic             receiving;
    logic             sample_tick;
    logic             frame_done;
    logic [CNT_W-1:0] cyc_cnt;
    logic [3:0]       bit_cnt;
    logic [8:0]       shreg;

    // line idles high, so the flops reset to one
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_pin;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall_edge   = rx_prev & ~rx_sync;
    assign sample_tick = receiving && (cyc_cnt == '0);

    // half a bit to the first sample, then one sample per bit
    always_ff @(posedge clk) begin
        if (rst) begin
            receiving  <= 1'b0;
            frame_done <= 1'b0;
            cyc_cnt    <= '0;
            bit_cnt    <= '0;
        end else begin
            frame_done <= 1'b0;
            if (!receiving) begin
                if (fall_edge) begin
                    receiving <= 1'b1;
                    cyc_cnt   <= HALF_BIT;
                    bit_cnt   <= '0;
                end
            end else if (sample_tick) begin
                cyc_cnt <= FULL_BIT;
                if (bit_cnt == LAST_BIT) begin
                    receiving  <= 1'b0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else begin
                cyc_cnt <= cyc_cnt - 1'b1;
            end
        end
    end

    // start bit drops off the end, stop bit ends up in bit 8
    always_ff @(posedge clk) begin
        if (sample_tick) begin
            shreg <= {rx_sync, shreg[8:1]};
        end
    end

    assign rx_byte    = shreg[7:0];
    assign byte_valid = frame_done & shreg[8];

endmodule

`default_nettype wire

//--- hw/uart_reply_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_reply_tx #(
    parameter int CYC_PER_BIT = 20
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  send_ack,
    input  wire  send_nak,
    output logic tx,
    output logic busy
);

    localparam int FRAME_W = xmodem_pkg::UART_FRAME_BITS;
    localparam int CNT_W   = $clog2(CYC_PER_BIT + 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CYC_PER_BIT - 1);
    localparam logic [3:0] LAST_BIT = 4'(FRAME_W - 1);

    logic [FRAME_W-1:0] frame;
    logic [CNT_W-1:0]   cyc_cnt;
    logic [3:0]         bit_cnt;
    logic [7:0]         code;

    assign code = send_ack ? xmodem_pkg::ACK_BYTE : xmodem_pkg::NAK_BYTE;

    // requests while busy are dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            frame   <= '1;
            busy    <= 1'b0;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (send_ack || send_nak) begin
                frame   <= {1'b1, code, 1'b0};
                busy    <= 1'b1;
                cyc_cnt <= FULL_BIT;
                bit_cnt <= '0;
            end
        end else if (cyc_cnt == '0) begin
            cyc_cnt <= FULL_BIT;
            if (bit_cnt == LAST_BIT) begin
                // stop bit stays on the line while idle
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
                frame   <= {1'b1, frame[FRAME_W-1:1]};
            end
        end else begin
            cyc_cnt <= cyc_cnt - 1'b1;
        end
    end

    assign tx = frame[0];

endmodule

`default_nettype wire

//--- hw/xmodem_block_parser.sv
`timescale 1ns/1ps
`default_nettype none

module xmodem_block_parser (
    input  wire        clk,
    input  wire        rst,
    input  wire  [7:0] rx_byte,
    input  wire        byte_valid,
    output logic [7:0] data,
    output logic       data_valid,
    output logic       repeat_block,
    output logic       block_ok,
    output logic       block_bad,
    output logic       eot_seen
);

    localparam logic [2:0] ST_HEADER = 3'd0;
    localparam logic [2:0] ST_NUM    = 3'd1;
    localparam logic [2:0] ST_CMPL   = 3'd2;
    localparam logic [2:0] ST_DATA   = 3'd3;
    localparam logic [2:0] ST_CSUM   = 3'd4;

    localparam logic [6:0] LAST_DATA = 7'(xmodem_pkg::BLOCK_DATA_BYTES - 1);

    logic [2:0] state;
    logic [7:0] block_num;
    logic [7:0] prev_num;
    logic [7:0] sum;
    logic [6:0] byte_cnt;
    logic       num_err;
    logic       cmpl_ok;
    logic       num_in_window;
    logic       sum_ok;

    assign cmpl_ok       = (rx_byte == ~block_num);
    // same block again or the next one, with 8-bit wrap
    assign num_in_window = (block_num == prev_num) || (block_num == prev_num + 8'd1);
    assign sum_ok        = (rx_byte == sum);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= ST_HEADER;
            prev_num     <= 8'h00;
            sum          <= 8'h00;
            byte_cnt     <= '0;
            num_err      <= 1'b0;
            repeat_block <= 1'b0;
            data_valid   <= 1'b0;
            block_ok     <= 1'b0;
            block_bad    <= 1'b0;
            eot_seen     <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            block_ok   <= 1'b0;
            block_bad  <= 1'b0;
            eot_seen   <= 1'b0;
            if (byte_valid) begin
                case (state)
                    ST_HEADER: begin
                        // anything other than SOH or EOT is line noise here
                        if (rx_byte == xmodem_pkg::SOH_BYTE) begin
                            state        <= ST_NUM;
                            repeat_block <= 1'b0;
                            sum          <= 8'h00;
                            byte_cnt     <= '0;
                        end else if (rx_byte == xmodem_pkg::EOT_BYTE) begin
                            eot_seen <= 1'b1;
                        end
                    end
                    ST_NUM: begin
                        state <= ST_CMPL;
                    end
                    ST_CMPL: begin
                        num_err      <= !(cmpl_ok && num_in_window);
                        repeat_block <= (block_num == prev_num);
                        state        <= ST_DATA;
                    end
                    ST_DATA: begin
                        sum        <= sum + rx_byte;
                        data_valid <= 1'b1;
                        byte_cnt   <= byte_cnt + 7'd1;
                        if (byte_cnt == LAST_DATA) begin
                            state <= ST_CSUM;
                        end
                    end
                    ST_CSUM: begin
                        if (!num_err && sum_ok) begin
                            block_ok <= 1'b1;
                            prev_num <= block_num;
                        end else begin
                            block_bad <= 1'b1;
                        end
                        state <= ST_HEADER;
                    end
                    default: begin
                        state <= ST_HEADER;
                    end
                endcase
            end
        end
    end

    // block number and data word
    always_ff @(posedge clk) begin
        if (byte_valid && state == ST_NUM) begin
            block_num <= rx_byte;
        end
        if (byte_valid && state == ST_DATA) begin
            data <= rx_byte;
        end
    end

endmodule

`default_nettype wire

//--- hw/xmodem_pkg.sv
`default_nettype none

package xmodem_pkg;

    // xmodem control codes
    localparam logic [7:0] SOH_BYTE = 8'h01;
    localparam logic [7:0] EOT_BYTE = 8'h04;
    localparam logic [7:0] ACK_BYTE = 8'h06;
    localparam logic [7:0] NAK_BYTE = 8'h15;

    // message bytes in one block, checksum variant
    localparam int BLOCK_DATA_BYTES = 128;

    // start bit, 8 data bits, stop bit
    localparam int UART_FRAME_BITS = 10;

endpackage

`default_nettype wire

//--- hw/xmodem_rx.sv
`timescale 1ns/1ps
`default_nettype none

module xmodem_rx #(
    parameter int CYC_PER_BIT = 20,
    parameter int MAX_RETRY   = 10
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       rx_pin,
    input  wire       start,
    output wire       tx,
    output wire [7:0] data,
    output wire       data_valid,
    output wire       repeat_block,
    output wire       block_ok,
    output wire       block_bad,
    output wire       done,
    output wire       aborted
);

    wire [7:0] rx_byte;
    wire       byte_valid;
    wire       eot_seen;
    wire       send_ack;
    wire       send_nak;
    wire       tx_busy;

    uart_byte_rx #(
        .CYC_PER_BIT(CYC_PER_BIT)
    ) uart_byte_rx_inst (
        .clk(clk),
        .rst(rst),
        .rx_pin(rx_pin),
        .rx_byte(rx_byte),
        .byte_valid(byte_valid)
    );

    xmodem_block_parser xmodem_block_parser_inst (
        .clk(clk),
        .rst(rst),
        .rx_byte(rx_byte),
        .byte_valid(byte_valid),
        .data(data),
        .data_valid(data_valid),
        .repeat_block(repeat_block),
        .block_ok(block_ok),
        .block_bad(block_bad),
        .eot_seen(eot_seen)
    );

    xmodem_session_ctrl #(
        .MAX_RETRY(MAX_RETRY)
    ) xmodem_session_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .start(start),
        .block_ok(block_ok),
        .block_bad(block_bad),
        .eot_seen(eot_seen),
        .send_ack(send_ack),
        .send_nak(send_nak),
        .done(done),
        .aborted(aborted)
    );

    // reply path back to the sender
    uart_reply_tx #(
        .CYC_PER_BIT(CYC_PER_BIT)
    ) uart_reply_tx_inst (
        .clk(clk),
        .rst(rst),
        .send_ack(send_ack),
        .send_nak(send_nak),
        .tx(tx),
        .busy(tx_busy)
    );

endmodule

`default_nettype wire

//--- hw/xmodem_session_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module xmodem_session_ctrl #(
    parameter int MAX_RETRY = 10
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  start,
    input  wire  block_ok,
    input  wire  block_bad,
    input  wire  eot_seen,
    output logic send_ack,
    output logic send_nak,
    output logic done,
    output logic aborted
);

    localparam int RETRY_W = $clog2(MAX_RETRY + 1);
    localparam logic [RETRY_W-1:0] LAST_RETRY = RETRY_W'(MAX_RETRY - 1);

    logic               active;
    logic [RETRY_W-1:0] retry_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            retry_cnt <= '0;
            send_ack  <= 1'b0;
            send_nak  <= 1'b0;
            done      <= 1'b0;
            aborted   <= 1'b0;
        end else begin
            send_ack <= 1'b0;
            send_nak <= 1'b0;
            done     <= 1'b0;
            aborted  <= 1'b0;
            if (!active) begin
                // receiver opens the session with a NAK
                if (start) begin
                    send_nak  <= 1'b1;
                    active    <= 1'b1;
                    retry_cnt <= '0;
                end
            end else if (eot_seen) begin
                send_ack <= 1'b1;
                done     <= 1'b1;
                active   <= 1'b0;
            end else if (block_ok) begin
                send_ack  <= 1'b1;
                retry_cnt <= '0;
            end else if (block_bad) begin
                send_nak <= 1'b1;
                // give up after too many bad blocks in a row
                if (retry_cnt == LAST_RETRY) begin
                    aborted   <= 1'b1;
                    active    <= 1'b0;
                    retry_cnt <= '0;
                end else begin
                    retry_cnt <= retry_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim.f
hw/xmodem_pkg.sv
hw/uart_byte_rx.sv
hw/xmodem_block_parser.sv
hw/xmodem_session_ctrl.sv
hw/uart_reply_tx.sv
hw/xmodem_rx.sv
verification/xmodem_rx_assertions.sv
verification/xmodem_rx_tb.sv

//--- verification/xmodem_rx_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module xmodem_rx_assertions (
    input wire clk,
    input wire rst,
    input wire block_ok,
    input wire block_bad,
    input wire tx,
    input wire busy,
    input wire done,
    input wire aborted
);

    int fail_count = 0;

    // one verdict per block
    result_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(block_ok && block_bad))
    else begin
        fail_count++;
        $error("block_ok and block_bad high in the same cycle");
    end

    // line idles at the stop level
    tx_idle_high: assert property (@(posedge clk) disable iff (rst) !busy |-> tx)
    else begin
        fail_count++;
        $error("tx low while the transmitter is idle");
    end

    session_end_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(done && aborted))
    else begin
        fail_count++;
        $error("done and aborted high in the same cycle");
    end

endmodule

bind xmodem_rx xmodem_rx_assertions xmodem_rx_assertions_inst (
    .clk(clk),
    .rst(rst),
    .block_ok(block_ok),
    .block_bad(block_bad),
    .tx(tx),
    .busy(tx_busy),
    .done(done),
    .aborted(aborted)
);

`default_nettype wire

//--- verification/xmodem_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module xmodem_rx_tb;

    localparam int CYC_PER_BIT = 20;
    localparam int MAX_RETRY   = 3;
    localparam int BLOCK_BYTES = xmodem_pkg::BLOCK_DATA_BYTES;
    localparam int FRAME_CYC   = xmodem_pkg::UART_FRAME_BITS * CYC_PER_BIT;
    // nine blocks of SOH, number, complement, data, checksum, then one EOT
    localparam int TEST_FRAMES = 9 * (BLOCK_BYTES + 4) + 1;
    localparam int WATCHDOG_NS = TEST_FRAMES * FRAME_CYC * 4 * 2;

    logic       clk = 1'b0;
    logic       rst;
    logic       rx_pin;
    logic       start;
    logic       tx;
    logic [7:0] data;
    logic       data_valid;
    logic       repeat_block;
    logic       block_ok;
    logic       block_bad;
    logic       done;
    logic       aborted;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng_state = 32'd39334;
    logic [7:0]  blk_data [0:BLOCK_BYTES-1];

    // model of the receiver as seen from the sender
    logic [7:0] prev_good = 8'h00;
    logic       session_active = 1'b0;
    int         retry = 0;
    int         exp_done = 0;
    int         exp_aborted = 0;
    int         replies_expected = 0;
    int         results_sent = 0;

    logic [7:0] exp_data [$];
    logic [7:0] exp_replies [$];
    logic       exp_good [$];
    logic       exp_repeat [$];
    logic       good_exp;
    int         replies_seen = 0;
    int         results_seen = 0;
    int         done_seen = 0;
    int         aborted_seen = 0;

    always #2 clk = ~clk;

    xmodem_rx #(
        .CYC_PER_BIT(CYC_PER_BIT),
        .MAX_RETRY(MAX_RETRY)
    ) xmodem_rx_inst (
        .clk(clk),
        .rst(rst),
        .rx_pin(rx_pin),
        .start(start),
        .tx(tx),
        .data(data),
        .data_valid(data_valid),
        .repeat_block(repeat_block),
        .block_ok(block_ok),
        .block_bad(block_bad),
        .done(done),
        .aborted(aborted)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // fills blk_data and returns {expected reply, checksum byte to send}
    function automatic logic [15:0] build_block(input logic [7:0] num,
                                                input logic [7:0] cmpl,
                                                input logic corrupt,
                                                input logic [7:0] prev);
        logic [7:0] sum;
        logic [7:0] csum;
        logic       good;
        sum = 8'h00;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            rng_state   = xorshift32(rng_state);
            blk_data[i] = rng_state[7:0];
            sum         = sum + rng_state[7:0];
        end
        csum = corrupt ? ~sum : sum;
        good = (cmpl == ~num) && ((num == prev) || (num == prev + 8'd1)) && (csum == sum);
        return {good ? xmodem_pkg::ACK_BYTE : xmodem_pkg::NAK_BYTE, csum};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %0h expected %0h", name, got, exp);
        end
    endtask

    // start bit, data LSB first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_pin <= frame[i];
            repeat (CYC_PER_BIT) @(posedge clk);
        end
    endtask

    // wait for every pending verdict and reply, then a quiet gap for strays
    task automatic settle();
        while (results_seen < results_sent || replies_seen < replies_expected) begin
            @(posedge clk);
        end
        repeat (3 * FRAME_CYC) @(posedge clk);
    endtask

    task automatic pulse_start();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (!session_active) begin
            exp_replies.push_back(xmodem_pkg::NAK_BYTE);
            replies_expected++;
            session_active = 1'b1;
            retry = 0;
        end
        settle();
    endtask

    task automatic send_block(input logic [7:0] num, input logic [7:0] cmpl,
                              input logic corrupt);
        logic [15:0] ref_out;
        logic        good;
        ref_out = build_block(num, cmpl, corrupt, prev_good);
        good    = (ref_out[15:8] == xmodem_pkg::ACK_BYTE);
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            exp_data.push_back(blk_data[i]);
        end
        exp_good.push_back(good);
        exp_repeat.push_back(num == prev_good);
        results_sent++;
        if (session_active) begin
            exp_replies.push_back(ref_out[15:8]);
            replies_expected++;
            if (good) begin
                retry = 0;
            end else begin
                retry++;
                if (retry == MAX_RETRY) begin
                    exp_aborted++;
                    session_active = 1'b0;
                    retry = 0;
                end
            end
        end
        if (good) begin
            prev_good = num;
        end
        send_byte(xmodem_pkg::SOH_BYTE);
        send_byte(num);
        send_byte(cmpl);
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            send_byte(blk_data[i]);
        end
        send_byte(ref_out[7:0]);
        settle();
    endtask

    task automatic send_eot();
        if (session_active) begin
            exp_replies.push_back(xmodem_pkg::ACK_BYTE);
            replies_expected++;
            exp_done++;
            session_active = 1'b0;
        end
        send_byte(xmodem_pkg::EOT_BYTE);
        settle();
    endtask

    // data bytes and block verdicts in arrival order
    always @(negedge clk) begin
        if (!rst) begin
            if (data_valid) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("data_valid pulsed with no data byte expected");
                end else begin
                    check_value("data", data, exp_data.pop_front());
                end
            end
            if (block_ok || block_bad) begin
                results_seen++;
                if (exp_good.size() == 0) begin
                    errors++;
                    $display("block verdict arrived with no block outstanding");
                end else begin
                    good_exp = exp_good.pop_front();
                    check_value("block_ok", block_ok, good_exp);
                    check_value("block_bad", block_bad, !good_exp);
                    check_value("repeat_block", repeat_block, exp_repeat.pop_front());
                end
            end
            if (done) begin
                done_seen++;
            end
            if (aborted) begin
                aborted_seen++;
            end
        end
    end

    // decode reply frames on tx
    initial begin
        logic [7:0] code;
        forever begin
            @(negedge clk);
            if (!rst && tx === 1'b0) begin
                repeat (CYC_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CYC_PER_BIT) @(negedge clk);
                    code[i] = tx;
                end
                repeat (CYC_PER_BIT) @(negedge clk);
                if (tx !== 1'b1) begin
                    errors++;
                    $display("reply frame on tx has a low stop bit");
                end
                replies_seen++;
                if (exp_replies.size() == 0) begin
                    errors++;
                    $display("unexpected reply byte %0h on tx", code);
                end else begin
                    check_value("tx", code, exp_replies.pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the test still running", WATCHDOG_NS);
        $display("checks %0d, errors %0d", checks, errors);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int assert_fails;
        rst    = 1'b1;
        start  = 1'b0;
        rx_pin = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        pulse_start();
        send_block(8'd1, ~8'd1, 1'b0);
        // bad checksum, then the same block again
        send_block(8'd2, ~8'd2, 1'b1);
        send_block(8'd2, ~8'd2, 1'b0);
        // duplicate of an acknowledged block
        send_block(8'd2, ~8'd2, 1'b0);
        // complement wrong until the session gives up
        repeat (MAX_RETRY) send_block(8'd3, 8'd3, 1'b0);
        // no reply while idle
        send_block(8'd3, ~8'd3, 1'b0);
        pulse_start();
        send_block(8'd4, ~8'd4, 1'b0);
        send_eot();

        if (exp_data.size() != 0 || exp_replies.size() != 0 || exp_good.size() != 0) begin
            errors++;
            $display("some expected data bytes, replies or block verdicts never arrived");
        end
        check_value("done count", done_seen, exp_done);
        check_value("aborted count", aborted_seen, exp_aborted);
        assert_fails = xmodem_rx_inst.xmodem_rx_assertions_inst.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
